//--- logic/dtlb_pkg.sv
`default_nettype none

// Widths and encodings shared by the TLB controller, the array and the top level
package dtlb_pkg;

   // Virtual and physical page numbers, 4 KiB pages on a 32-bit address
   localparam int VPN_W = 20;
   localparam int PPN_W = 20;

   // Set index and tag split of a VPN
   localparam int SET_W = 4;
   localparam int TAG_W = VPN_W - SET_W;

   // Default depth, top level may override through its parameter
   localparam int NUM_SETS = 16;

   // Page flags as stored in the array and returned to the requester
   localparam int FLAG_W = 4;

   // Bit positions inside a flag word
   // Same layout for page-directory flags, page-table flags and merged flags
   localparam int FLAG_PRESENT   = 0;
   localparam int FLAG_WRITEABLE = 1;
   localparam int FLAG_KERNEL    = 2;
   localparam int FLAG_GLOBAL    = 3;

   // A VPN seen two ways
   // raw for the walker address and request compares
   // f for the array, which splits it into tag and set index
   typedef union packed {
      logic [VPN_W-1:0] raw;
      struct packed {
         // Upper bits, compared against the stored tag
         logic [TAG_W-1:0] tag;
         // Lower bits, pick the set
         logic [SET_W-1:0] set_idx;
      } f;
   } vpn_t;

endpackage

`default_nettype wire

//--- logic/dtlb_array_if.sv
`default_nettype none

// Lookup and fill path between the controller and the translation array
interface dtlb_array_if import dtlb_pkg::*; ();

   // Driven by the controller
   // Read address, sampled by the array on every clock
   vpn_t              rd_vpn;
   // Write the walker result into the victim way of the registered set
   logic              fill;
   logic [PPN_W-1:0]  fill_ppn;
   logic [FLAG_W-1:0] fill_flags;
   // Steer the replacement bit away from the way that just hit
   logic              hit_upd;

   // Driven by the array, valid one cycle after rd_vpn
   logic              hit;
   logic [PPN_W-1:0]  hit_ppn;
   logic [FLAG_W-1:0] hit_flags;

   modport ctrl (
      output rd_vpn, fill, fill_ppn, fill_flags, hit_upd,
      input  hit, hit_ppn, hit_flags
   );

   modport array (
      input  rd_vpn, fill, fill_ppn, fill_flags, hit_upd,
      output hit, hit_ppn, hit_flags
   );

endinterface

`default_nettype wire

//--- logic/dtlb_array.sv
`default_nettype none

// Two-way set associative translation store
// One replacement bit per set, value is the way to evict next
module dtlb_array import dtlb_pkg::*; #(
   parameter int NUM_SETS = dtlb_pkg::NUM_SETS
) (
   input  logic        clk,
   input  logic        rst_n,
   dtlb_array_if.array arr
);

   // Registered read address, also the target of hit updates and fills
   logic [TAG_W-1:0]             rd_tag_q;
   logic [SET_W-1:0]             rd_set_q;

   // Per-way read results
   logic [1:0]                   hit_way;
   logic [1:0][PPN_W-1:0]        way_ppn;
   logic [1:0][FLAG_W-1:0]       way_flags;

   // Replacement state
   logic [NUM_SETS-1:0]          repl;
   logic                         fill_way;

   // Set and tag of the lookup, held for one cycle
   always_ff @(posedge clk) begin
      rd_tag_q <= arr.rd_vpn.f.tag;
      rd_set_q <= arr.rd_vpn.f.set_idx;
   end

   // Victim way of the set under compare
   assign fill_way = repl[rd_set_q];

   for (genvar w = 0; w < 2; w++) begin : g_way
      logic [TAG_W-1:0]    tag_mem  [NUM_SETS];
      logic [PPN_W-1:0]    ppn_mem  [NUM_SETS];
      logic [FLAG_W-1:0]   flag_mem [NUM_SETS];
      logic [NUM_SETS-1:0] valid;
      logic [TAG_W-1:0]    tag_q;
      logic [PPN_W-1:0]    ppn_q;
      logic [FLAG_W-1:0]   flags_q;
      logic                valid_q;
      logic                we;

      // Only the way picked by the replacement bit takes the fill
      assign we = arr.fill && (fill_way == 1'(w));

      // Entry payload, written at the registered set
      // Read port is synchronous on the live set index
      always_ff @(posedge clk) begin
         if (we) begin
            tag_mem[rd_set_q]  <= rd_tag_q;
            ppn_mem[rd_set_q]  <= arr.fill_ppn;
            flag_mem[rd_set_q] <= arr.fill_flags;
         end
         tag_q   <= tag_mem[arr.rd_vpn.f.set_idx];
         ppn_q   <= ppn_mem[arr.rd_vpn.f.set_idx];
         flags_q <= flag_mem[arr.rd_vpn.f.set_idx];
      end

      // Valid bits start cleared, entries are never invalidated afterwards
      always_ff @(posedge clk) begin
         if (!rst_n) begin
            valid   <= '0;
            valid_q <= 1'b0;
         end else begin
            if (we) begin
               valid[rd_set_q] <= 1'b1;
            end
            valid_q <= valid[arr.rd_vpn.f.set_idx];
         end
      end

      // Tag compare against the registered lookup tag
      assign hit_way[w]   = valid_q && (tag_q == rd_tag_q);
      assign way_ppn[w]   = ppn_q;
      assign way_flags[w] = flags_q;
   end

   // At most one way hits, so way 1's bit alone selects the data
   assign arr.hit       = |hit_way;
   assign arr.hit_ppn   = way_ppn[hit_way[1]];
   assign arr.hit_flags = way_flags[hit_way[1]];

   // Fill flips the bit, a hit on way 0 points at way 1 and vice versa
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         repl <= '0;
      end else if (arr.fill) begin
         repl[rd_set_q] <= ~repl[rd_set_q];
      end else if (arr.hit_upd) begin
         repl[rd_set_q] <= hit_way[0];
      end
   end

   // A tag is only filled after missing in both ways of its set
   a_single_way_hit: assert property (
      @(posedge clk) disable iff (!rst_n) !(hit_way[0] && hit_way[1])
   );

endmodule

`default_nettype wire

//--- logic/dtlb_ctrl.sv
`default_nettype none

// Lookup FSM of the data TLB
// idle -> compare on a request, compare -> walk on a miss, walk -> idle after response
module dtlb_ctrl import dtlb_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,

   // Requester
   input  logic              req_re,
   input  vpn_t              req_vpn,
   output logic              ready,

   // Response, one-cycle strobe
   output logic              resp_valid,
   output logic [PPN_W-1:0]  resp_ppn,
   output logic [FLAG_W-1:0] resp_flags,

   // Page table walker
   output logic              ptw_re,
   output logic [VPN_W-1:0]  ptw_vpn,
   input  logic              ptw_ready,
   input  logic [PPN_W-1:0]  ptw_ppn,
   input  logic [FLAG_W-1:0] ptw_pagedir_flags,
   input  logic [FLAG_W-1:0] ptw_pagetab_flags,

   // Page directory base, passed straight to the walker
   input  logic [PPN_W-1:0]  pagedir_base,
   output logic [PPN_W-1:0]  ptw_pagedir_base,

   dtlb_array_if.ctrl        arr
);

   localparam logic [1:0] S_IDLE = 2'd0;
   localparam logic [1:0] S_CMP  = 2'd1;
   localparam logic [1:0] S_WALK = 2'd2;

   logic [1:0]        state;
   logic [1:0]        state_nxt;
   vpn_t              vpn_q;
   logic              accept;
   logic              cmp_hit;
   logic              cmp_miss;
   // Walk in flight, walker has not answered yet
   logic              walk_wait;
   // Miss response cycle
   logic              resp_q;
   logic [PPN_W-1:0]  walk_ppn_q;
   logic [FLAG_W-1:0] walk_flags_q;
   logic [FLAG_W-1:0] merged_flags;

   // Array data arrives in the compare cycle
   assign cmp_hit   = (state == S_CMP) && arr.hit;
   assign cmp_miss  = (state == S_CMP) && !arr.hit;
   assign walk_wait = (state == S_WALK) && !resp_q;

   // Open in idle and on a hit, so hits stream back to back
   assign ready  = (state == S_IDLE) || cmp_hit;
   assign accept = req_re && ready;

   // Live VPN when a new request can enter, otherwise the one being served
   assign arr.rd_vpn = ready ? req_vpn : vpn_q;

   always_comb begin
      state_nxt = state;
      case (state)
         S_IDLE: begin
            if (req_re) begin
               state_nxt = S_CMP;
            end
         end
         S_CMP: begin
            if (!arr.hit) begin
               state_nxt = S_WALK;
            end else if (!req_re) begin
               state_nxt = S_IDLE;
            end
         end
         // Leave once the miss response has gone out
         S_WALK: begin
            if (resp_q) begin
               state_nxt = S_IDLE;
            end
         end
         default: state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state  <= S_IDLE;
         resp_q <= 1'b0;
      end else begin
         state  <= state_nxt;
         resp_q <= walk_wait && ptw_ready;
      end
   end

   // Request latch, also holds the walk address
   always_ff @(posedge clk) begin
      if (accept) begin
         vpn_q <= req_vpn;
      end
   end

   // Present and writeable need both levels, kernel and global take either
   always_comb begin
      merged_flags = ptw_pagedir_flags & ptw_pagetab_flags;
      merged_flags[FLAG_KERNEL] = ptw_pagedir_flags[FLAG_KERNEL] |
                                  ptw_pagetab_flags[FLAG_KERNEL];
      merged_flags[FLAG_GLOBAL] = ptw_pagedir_flags[FLAG_GLOBAL] |
                                  ptw_pagetab_flags[FLAG_GLOBAL];
   end

   // Walker result, returned in the cycle after ptw_ready
   always_ff @(posedge clk) begin
      if (walk_wait && ptw_ready) begin
         walk_ppn_q   <= ptw_ppn;
         walk_flags_q <= merged_flags;
      end
   end

   // Single-cycle walk start straight out of the compare
   assign ptw_re           = cmp_miss;
   assign ptw_vpn          = vpn_q.raw;
   assign ptw_pagedir_base = pagedir_base;

   // Fill lands at the latched set while the read address still points there
   assign arr.fill       = walk_wait && ptw_ready;
   assign arr.fill_ppn   = ptw_ppn;
   assign arr.fill_flags = merged_flags;
   assign arr.hit_upd    = cmp_hit;

   assign resp_valid = cmp_hit || resp_q;
   assign resp_ppn   = resp_q ? walk_ppn_q : arr.hit_ppn;
   assign resp_flags = resp_q ? walk_flags_q : arr.hit_flags;

   // One walk per miss
   a_ptw_re_pulse: assert property (
      @(posedge clk) disable iff (!rst_n) ptw_re |=> !ptw_re
   );

   // Walker may sample the address at any point until it answers
   a_ptw_vpn_hold: assert property (
      @(posedge clk) disable iff (!rst_n)
      (ptw_re || (walk_wait && !ptw_ready)) |=> $stable(ptw_vpn)
   );

endmodule

`default_nettype wire

//--- logic/dtlb_top.sv
`default_nettype none

// Single-port data TLB, 2 ways
module dtlb_top import dtlb_pkg::*; #(
   parameter int NUM_SETS = dtlb_pkg::NUM_SETS
) (
   input  logic              clk,
   input  logic              rst_n,

   // Lookup request
   input  logic              req_re,
   input  logic [VPN_W-1:0]  req_vpn,
   output logic              ready,

   // Translation result
   output logic              resp_valid,
   output logic [PPN_W-1:0]  resp_ppn,
   output logic [FLAG_W-1:0] resp_flags,

   // External page table walker
   output logic              ptw_re,
   output logic [VPN_W-1:0]  ptw_vpn,
   output logic [PPN_W-1:0]  ptw_pagedir_base,
   input  logic              ptw_ready,
   input  logic [PPN_W-1:0]  ptw_ppn,
   input  logic [FLAG_W-1:0] ptw_pagedir_flags,
   input  logic [FLAG_W-1:0] ptw_pagetab_flags,

   // Page directory base, page aligned
   input  logic [PPN_W-1:0]  pagedir_base
);

   dtlb_array_if arr_if ();

   dtlb_ctrl u_ctrl (
      .clk               (clk),
      .rst_n             (rst_n),
      .req_re            (req_re),
      .req_vpn           (req_vpn),
      .ready             (ready),
      .resp_valid        (resp_valid),
      .resp_ppn          (resp_ppn),
      .resp_flags        (resp_flags),
      .ptw_re            (ptw_re),
      .ptw_vpn           (ptw_vpn),
      .ptw_ready         (ptw_ready),
      .ptw_ppn           (ptw_ppn),
      .ptw_pagedir_flags (ptw_pagedir_flags),
      .ptw_pagetab_flags (ptw_pagetab_flags),
      .pagedir_base      (pagedir_base),
      .ptw_pagedir_base  (ptw_pagedir_base),
      .arr               (arr_if.ctrl)
   );

   // Storage depth follows the top-level parameter
   dtlb_array #(
      .NUM_SETS (NUM_SETS)
   ) u_array (
      .clk   (clk),
      .rst_n (rst_n),
      .arr   (arr_if.array)
   );

endmodule

`default_nettype wire

//--- include/dtlb_tb_ref.svh
`ifndef DTLB_TB_REF_SVH
`define DTLB_TB_REF_SVH

// Two-way model of the TLB contents, one replacement bit per set
logic             model_valid [NUM_SETS][2];
logic [TAG_W-1:0] model_tag   [NUM_SETS][2];
logic             model_repl  [NUM_SETS];

function automatic logic [31:0] xorshift32(input logic [31:0] s);
   logic [31:0] x;
   x = s;
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   return x;
endfunction

// Walker page data, a fixed hash of the VPN
function automatic logic [31:0] page_hash(input logic [VPN_W-1:0] vpn);
   return xorshift32(xorshift32({12'h5A3, vpn}));
endfunction

function automatic logic [PPN_W-1:0] page_ppn(input logic [VPN_W-1:0] vpn);
   logic [31:0] h;
   h = page_hash(vpn);
   return h[PPN_W-1:0];
endfunction

function automatic logic [FLAG_W-1:0] pagedir_flags(input logic [VPN_W-1:0] vpn);
   logic [31:0] h;
   h = page_hash(vpn);
   return h[23:20];
endfunction

function automatic logic [FLAG_W-1:0] pagetab_flags(input logic [VPN_W-1:0] vpn);
   logic [31:0] h;
   h = page_hash(vpn);
   return h[27:24];
endfunction

// Present and writeable need both levels, kernel and global need either
function automatic logic [FLAG_W-1:0] merge_flags(input logic [FLAG_W-1:0] pd,
                                                  input logic [FLAG_W-1:0] pt);
   logic [FLAG_W-1:0] m;
   m[FLAG_PRESENT]   = pd[FLAG_PRESENT] & pt[FLAG_PRESENT];
   m[FLAG_WRITEABLE] = pd[FLAG_WRITEABLE] & pt[FLAG_WRITEABLE];
   m[FLAG_KERNEL]    = pd[FLAG_KERNEL] | pt[FLAG_KERNEL];
   m[FLAG_GLOBAL]    = pd[FLAG_GLOBAL] | pt[FLAG_GLOBAL];
   return m;
endfunction

function automatic void model_clear();
   for (int s = 0; s < NUM_SETS; s++) begin
      model_valid[s][0] = 1'b0;
      model_valid[s][1] = 1'b0;
      model_repl[s]     = 1'b0;
   end
endfunction

// Returns 1 on a hit, on a miss fills the way the bit selects
function automatic logic model_lookup(input logic [VPN_W-1:0] vpn);
   logic [SET_W-1:0] s;
   logic [TAG_W-1:0] t;
   logic             w;
   s = vpn[SET_W-1:0];
   t = vpn[VPN_W-1:SET_W];
   for (int i = 0; i < 2; i++) begin
      if (model_valid[s][i] && model_tag[s][i] == t) begin
         // Point the bit at the other way
         model_repl[s] = (i == 0);
         return 1'b1;
      end
   end
   w = model_repl[s];
   model_valid[s][w] = 1'b1;
   model_tag[s][w]   = t;
   model_repl[s]     = ~w;
   return 1'b0;
endfunction

`endif

//--- test/dtlb_tb.sv
`default_nettype none

// Testbench for the data TLB with a walker model and a two-way reference model
module dtlb_tb import dtlb_pkg::*; ();

   // Request counts per test, they set the cycle limit
   localparam int N_FIRST     = 4;
   localparam int N_BURST     = 8;
   localparam int N_SET       = 5;
   localparam int N_RAND      = 300;
   localparam int N_AFTER     = 3;
   localparam int NUM_REQ     = 2 * N_FIRST + N_BURST + N_SET + N_RAND + N_AFTER;
   localparam int CYCLE_LIMIT = 20 * NUM_REQ + 100;

   // One VPN each in sets 5, 1, 2 and 3
   localparam logic [VPN_W-1:0] FIRST_VPNS [N_FIRST] = '{
      20'h12345, 20'h0ABC1, 20'hFFFF2, 20'h00013
   };
   // Three tags sharing set 9
   localparam logic [VPN_W-1:0] VPN_A = 20'h00A09;
   localparam logic [VPN_W-1:0] VPN_B = 20'h00B09;
   localparam logic [VPN_W-1:0] VPN_C = 20'h00C09;

   logic              clk;
   logic              rst_n;
   logic              req_re;
   logic [VPN_W-1:0]  req_vpn;
   logic              ready;
   logic              resp_valid;
   logic [PPN_W-1:0]  resp_ppn;
   logic [FLAG_W-1:0] resp_flags;
   logic              ptw_re;
   logic [VPN_W-1:0]  ptw_vpn;
   logic [PPN_W-1:0]  ptw_pagedir_base;
   logic              ptw_ready;
   logic [PPN_W-1:0]  ptw_ppn;
   logic [FLAG_W-1:0] ptw_pagedir_flags;
   logic [FLAG_W-1:0] ptw_pagetab_flags;
   logic [PPN_W-1:0]  pagedir_base;

   int cycle_count = 0;
   int walk_count  = 0;
   int err_count   = 0;
   // Accepted requests still waiting for their response, oldest first
   logic [VPN_W-1:0] pending [$];
   int               accept_at [$];

   `include "dtlb_tb_ref.svh"

   dtlb_top #(
      .NUM_SETS (NUM_SETS)
   ) DUT (
      .clk               (clk),
      .rst_n             (rst_n),
      .req_re            (req_re),
      .req_vpn           (req_vpn),
      .ready             (ready),
      .resp_valid        (resp_valid),
      .resp_ppn          (resp_ppn),
      .resp_flags        (resp_flags),
      .ptw_re            (ptw_re),
      .ptw_vpn           (ptw_vpn),
      .ptw_pagedir_base  (ptw_pagedir_base),
      .ptw_ready         (ptw_ready),
      .ptw_ppn           (ptw_ppn),
      .ptw_pagedir_flags (ptw_pagedir_flags),
      .ptw_pagetab_flags (ptw_pagetab_flags),
      .pagedir_base      (pagedir_base)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Cycle count, also the run limit
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > CYCLE_LIMIT) begin
         $display("timeout: response never arrived");
         $display("Done: errors found");
         $fatal(1, "cycle limit reached");
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         err_count++;
         $display("[FAIL] t=%0t %s got=%h expected=%h", $time, name, got, exp);
         $display("Done: errors found");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic report_error(input string what);
      err_count++;
      $display("%0t: %s", $time, what);
      $display("Done: errors found");
      $fatal(1, "stopped at first error");
   endtask

   // Walker answers each start after 1 to 4 cycles
   initial begin : walker
      logic [31:0]      walk_rng;
      logic [VPN_W-1:0] vpn;
      int               delay;
      walk_rng          = 32'd44;
      ptw_ready         = 1'b0;
      ptw_ppn           = '0;
      ptw_pagedir_flags = '0;
      ptw_pagetab_flags = '0;
      forever begin
         @(negedge clk);
         if (ptw_re) begin
            vpn      = ptw_vpn;
            walk_rng = xorshift32(walk_rng);
            delay    = int'(walk_rng[1:0]) + 1;
            repeat (delay) @(posedge clk);
            #1;
            ptw_ready         = 1'b1;
            ptw_ppn           = page_ppn(vpn);
            ptw_pagedir_flags = pagedir_flags(vpn);
            ptw_pagetab_flags = pagetab_flags(vpn);
            @(posedge clk);
            #1;
            ptw_ready = 1'b0;
         end
      end
   end

   // Compares every response and walk against the model, sampled mid cycle
   initial begin : compare
      logic [VPN_W-1:0] vpn;
      logic             exp_hit;
      logic             walked;
      int               acc;
      int               ready_cycle;
      walked      = 1'b0;
      ready_cycle = 0;
      forever begin
         @(negedge clk);
         if (!rst_n) begin
            model_clear();
            walked = 1'b0;
         end else begin
            if (resp_valid) begin
               if (pending.size() == 0) begin
                  report_error("response arrived with no request outstanding");
               end else begin
                  vpn     = pending.pop_front();
                  acc     = accept_at.pop_front();
                  exp_hit = model_lookup(vpn);
                  check_value("ptw_re (walk taken)", 32'(walked), 32'(!exp_hit));
                  check_value("resp_ppn", 32'(resp_ppn), 32'(page_ppn(vpn)));
                  check_value("resp_flags", 32'(resp_flags),
                              32'(merge_flags(pagedir_flags(vpn), pagetab_flags(vpn))));
                  // Hit answers next cycle with ready open, a miss one cycle after ptw_ready
                  if (exp_hit) begin
                     check_value("resp_valid cycle", cycle_count, acc + 1);
                     check_value("ready", 32'(ready), 32'd1);
                  end else begin
                     check_value("resp_valid cycle", cycle_count, ready_cycle + 1);
                     check_value("ready", 32'(ready), 32'd0);
                  end
                  walked = 1'b0;
               end
            end
            if (ptw_re) begin
               if (pending.size() == 0 || walked) begin
                  report_error("walk started without a request that needs one");
               end else begin
                  check_value("ptw_vpn", 32'(ptw_vpn), 32'(pending[0]));
                  check_value("ptw_pagedir_base", 32'(ptw_pagedir_base), 32'(pagedir_base));
                  // Walk starts in the compare cycle right after acceptance
                  check_value("ptw_re cycle", cycle_count, accept_at[0] + 1);
                  walked = 1'b1;
                  walk_count++;
               end
            end
            if (ptw_ready) begin
               ready_cycle = cycle_count;
               check_value("ptw_vpn", 32'(ptw_vpn), 32'(pending[0]));
            end
            if (req_re && ready) begin
               pending.push_back(req_vpn);
               accept_at.push_back(cycle_count);
            end
         end
      end
   end

   task automatic apply_reset();
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
   endtask

   task automatic check_idle_outputs();
      @(negedge clk);
      check_value("ready", 32'(ready), 32'd1);
      check_value("resp_valid", 32'(resp_valid), 32'd0);
      check_value("ptw_re", 32'(ptw_re), 32'd0);
      @(posedge clk);
      #1;
   endtask

   // Holds the request until an edge with ready high, returns that cycle
   task automatic issue(input logic [VPN_W-1:0] vpn, output int acc_cycle);
      logic done;
      done    = 1'b0;
      req_re  = 1'b1;
      req_vpn = vpn;
      while (!done) begin
         @(negedge clk);
         if (ready) begin
            done      = 1'b1;
            acc_cycle = cycle_count;
         end
         @(posedge clk);
         #1;
      end
      req_re = 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic wait_idle();
      do begin
         @(posedge clk);
         #1;
      end while (pending.size() != 0);
   endtask

   initial begin : stimulus
      logic [31:0]      stim_rng;
      logic [VPN_W-1:0] vpn;
      int               acc;
      int               prev_acc;
      int               walks_before;
      stim_rng     = 32'd44;
      req_re       = 1'b0;
      req_vpn      = '0;
      pagedir_base = 20'h3C0DE;
      rst_n        = 1'b0;
      apply_reset();
      check_idle_outputs();

      // Cold TLB, every first touch walks
      walks_before = walk_count;
      for (int i = 0; i < N_FIRST; i++) begin
         issue(FIRST_VPNS[i], acc);
      end
      wait_idle();
      check_value("walk count", walk_count - walks_before, N_FIRST);

      // Same VPNs again, all hits
      walks_before = walk_count;
      for (int i = 0; i < N_FIRST; i++) begin
         issue(FIRST_VPNS[i], acc);
         wait_idle();
      end
      check_value("walk count", walk_count - walks_before, 0);

      // Hits streamed with one acceptance per cycle
      walks_before = walk_count;
      prev_acc     = 0;
      for (int i = 0; i < N_BURST; i++) begin
         issue(FIRST_VPNS[i % N_FIRST], acc);
         if (i > 0) begin
            check_value("accept cycle", acc, prev_acc + 1);
         end
         prev_acc = acc;
      end
      wait_idle();
      check_value("walk count", walk_count - walks_before, 0);

      // A B A C B in one set, C evicts B so B walks again
      pagedir_base = 20'h51F00;
      walks_before = walk_count;
      issue(VPN_A, acc);
      issue(VPN_B, acc);
      issue(VPN_A, acc);
      issue(VPN_C, acc);
      issue(VPN_B, acc);
      wait_idle();
      check_value("walk count", walk_count - walks_before, 4);

      // 3 tags over 4 sets, random gaps of 0 to 3 cycles
      for (int i = 0; i < N_RAND; i++) begin
         stim_rng = xorshift32(stim_rng);
         vpn      = {16'h0100 + 16'(stim_rng % 3), 4'(stim_rng[9:8])};
         issue(vpn, acc);
         idle_cycles(int'(stim_rng[13:12]));
      end
      wait_idle();

      // Reset in the middle, cached entries must walk again
      apply_reset();
      check_idle_outputs();
      walks_before = walk_count;
      issue(FIRST_VPNS[0], acc);
      issue(VPN_C, acc);
      issue(VPN_B, acc);
      wait_idle();
      check_value("walk count", walk_count - walks_before, N_AFTER);

      if (err_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
logic/dtlb_pkg.sv
logic/dtlb_array_if.sv
logic/dtlb_array.sv
logic/dtlb_ctrl.sv
logic/dtlb_top.sv
test/dtlb_tb.sv

//--- Makefile
# Verilator build, run and lint for the data TLB

VERILATOR  ?= verilator
TOP        ?= dtlb_tb
RTL_TOP    ?= dtlb_top
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= Done: no errors
SOURCES    := $(wildcard logic/*.sv test/*.sv include/*.svh)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Passes only when the simulation output holds the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
